/* rtl/glyph_art.svh */
`ifndef GLYPH_ART_SVH
`define GLYPH_ART_SVH
`default_nettype none

localparam int NUM_GLYPHS = 20;

// indexed by glyph id, then cell row
localparam logic [7:0] GLYPH_ART [NUM_GLYPHS][8] = '{
    // digits 0 to 9
    '{8'b00000000, 8'b00000000, 8'b00111100, 8'b00100100,
      8'b00100100, 8'b00100100, 8'b00111100, 8'b00000000},
    '{8'b00000000, 8'b00010000, 8'b00010000, 8'b00010000,
      8'b00010000, 8'b00010000, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00111100, 8'b00100000, 8'b00111100,
      8'b00000100, 8'b00111100, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00111100, 8'b00100000, 8'b00111100,
      8'b00100000, 8'b00111100, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00100100, 8'b00100100, 8'b01111100,
      8'b00100000, 8'b00100000, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00111100, 8'b00000100, 8'b00111100,
      8'b00100000, 8'b00111100, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00111100, 8'b00000100, 8'b00111100,
      8'b00100100, 8'b00111100, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b00111100, 8'b00100100,
      8'b00100000, 8'b00100000, 8'b00100000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b00111100, 8'b00100100,
      8'b00111100, 8'b00100100, 8'b00111100, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b00111100, 8'b00100100,
      8'b00111100, 8'b00100000, 8'b00111100, 8'b00000000},
    // sharp, star
    '{8'b00000000, 8'b00100100, 8'b01111110, 8'b00100100,
      8'b00100100, 8'b01111110, 8'b00100100, 8'b00000000},
    '{8'b00000000, 8'b00010000, 8'b01010100, 8'b00111000,
      8'b00111000, 8'b01010100, 8'b00010000, 8'b00000000},
    // corner arrows nw, ne, se, sw
    '{8'b00000000, 8'b00100000, 8'b01111110, 8'b00100010,
      8'b00000010, 8'b00000010, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00111100, 8'b00100000, 8'b00100000,
      8'b00100000, 8'b01110000, 8'b00100000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b01000000, 8'b01000000,
      8'b01000100, 8'b01111110, 8'b00000100, 8'b00000000},
    '{8'b00000000, 8'b00000100, 8'b00001110, 8'b00000100,
      8'b00000100, 8'b00000100, 8'b00111100, 8'b00000000},
    // player tokens p1 to p4
    '{8'b00000000, 8'b00011000, 8'b00100100, 8'b01000010,
      8'b01000010, 8'b00100100, 8'b00011000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b00111100, 8'b00100100,
      8'b00100100, 8'b00111100, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b01111110, 8'b01000100,
      8'b00101000, 8'b00010000, 8'b00000000, 8'b00000000},
    '{8'b00000000, 8'b00000000, 8'b00100100, 8'b00111100,
      8'b01100110, 8'b00111000, 8'b00010000, 8'b00000000}
};

`default_nettype wire
`endif

/* rtl/board_pkg.sv */
`default_nettype none

package board_pkg;

    typedef logic [3:0] color_code_t;

    localparam color_code_t RED         = 4'd0;
    localparam color_code_t ORANGE      = 4'd1;
    localparam color_code_t YELLOW      = 4'd2;
    localparam color_code_t GREEN       = 4'd3;
    localparam color_code_t BLUE        = 4'd4;
    localparam color_code_t NAVY        = 4'd5;
    localparam color_code_t PURPLE      = 4'd6;
    localparam color_code_t WHITE       = 4'd7;
    localparam color_code_t BLACK       = 4'd8;
    localparam color_code_t SKYBLUE     = 4'd9;
    localparam color_code_t FORESTGREEN = 4'd10;
    localparam color_code_t GRAY        = 4'd11;
    localparam color_code_t BROWN       = 4'd12;

    // red in the top byte, blue in the bottom
    typedef logic [23:0] rgb_t;

    localparam int TILE_PX     = 80;
    localparam int BORDER_PX   = 2;
    localparam int CELL_PX     = 10;
    localparam int BOARD_X0    = 80;
    localparam int BOARD_COLS  = 8;
    localparam int BOARD_ROWS  = 6;
    localparam int NUM_EDGES   = 24;
    localparam int NUM_PLAYERS = 4;

    // register stages between lcd_timing and the panel pins
    localparam int RENDER_LATENCY = 2;

    typedef logic [2:0] tile_col_t;
    typedef logic [2:0] tile_row_t;
    typedef logic [2:0] cell_t;
    typedef logic [6:0] tile_offset_t;
    // 24 and up means off the board
    typedef logic [4:0] player_pos_t;
    typedef logic [4:0] glyph_t;

    // digits use their own value as id
    localparam glyph_t GLYPH_0     = 5'd0;
    localparam glyph_t GLYPH_SHARP = 5'd10;
    localparam glyph_t GLYPH_STAR  = 5'd11;
    localparam glyph_t GLYPH_NW    = 5'd12;
    localparam glyph_t GLYPH_NE    = 5'd13;
    localparam glyph_t GLYPH_SE    = 5'd14;
    localparam glyph_t GLYPH_SW    = 5'd15;
    localparam glyph_t GLYPH_P1    = 5'd16;
    localparam glyph_t GLYPH_P4    = 5'd19;

    `include "glyph_art.svh"

    function automatic rgb_t palette(input color_code_t code);
        case (code)
            RED:         return {8'd255, 8'd0, 8'd0};
            ORANGE:      return {8'd255, 8'd140, 8'd0};
            YELLOW:      return {8'd255, 8'd255, 8'd0};
            GREEN:       return {8'd50, 8'd205, 8'd50};
            BLUE:        return {8'd0, 8'd0, 8'd255};
            NAVY:        return {8'd0, 8'd0, 8'd128};
            PURPLE:      return {8'd148, 8'd0, 8'd211};
            WHITE:       return {8'd255, 8'd255, 8'd255};
            SKYBLUE:     return {8'd135, 8'd206, 8'd235};
            FORESTGREEN: return {8'd0, 8'd100, 8'd0};
            GRAY:        return {8'd128, 8'd128, 8'd128};
            BROWN:       return {8'd165, 8'd42, 8'd42};
            // black and the unused codes
            default:     return 24'h000000;
        endcase
    endfunction

    // bit 0 of a row is the leftmost cell
    function automatic logic glyph_bit(input glyph_t g, input cell_t cy, input cell_t cx);
        if (g > GLYPH_P4) begin
            return 1'b0;
        end
        return GLYPH_ART[g][cy][cx];
    endfunction

endpackage

`default_nettype wire

/* rtl/lcd_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 48,
    parameter int H_BACK   = 168,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 13,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 29
) (
    input  wire        clk,
    input  wire        rst,
    output logic [9:0] x,
    output logic [8:0] y,
    output logic       active,
    output logic       hsync,
    output logic       vsync
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    typedef logic [HW-1:0] h_cnt_t;
    typedef logic [VW-1:0] v_cnt_t;

    localparam h_cnt_t H_LAST   = h_cnt_t'(H_TOTAL - 1);
    localparam h_cnt_t H_VIS    = h_cnt_t'(H_ACTIVE);
    localparam h_cnt_t HS_BEGIN = h_cnt_t'(H_ACTIVE + H_FRONT);
    localparam h_cnt_t HS_END   = h_cnt_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam v_cnt_t V_LAST   = v_cnt_t'(V_TOTAL - 1);
    localparam v_cnt_t V_VIS    = v_cnt_t'(V_ACTIVE);
    localparam v_cnt_t VS_BEGIN = v_cnt_t'(V_ACTIVE + V_FRONT);
    localparam v_cnt_t VS_END   = v_cnt_t'(V_ACTIVE + V_FRONT + V_SYNC);

    h_cnt_t h_cnt;
    v_cnt_t v_cnt;

    // count 0 is the first visible pixel of a line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign x      = h_cnt[9:0];
    assign y      = v_cnt[8:0];
    assign active = (h_cnt < H_VIS) && (v_cnt < V_VIS);
    // both syncs are active low
    assign hsync  = !((h_cnt >= HS_BEGIN) && (h_cnt < HS_END));
    assign vsync  = !((v_cnt >= VS_BEGIN) && (v_cnt < VS_END));

endmodule

`default_nettype wire

/* rtl/tile_locator.sv */
`timescale 1ns/100ps
`default_nettype none

module tile_locator (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  [9:0]           x,
    input  wire  [8:0]           y,
    input  wire                  active,
    input  wire                  hsync,
    input  wire                  vsync,
    output logic                 on_board,
    output board_pkg::tile_row_t row,
    output board_pkg::tile_col_t col,
    output logic                 in_border,
    output board_pkg::cell_t     cell_x,
    output board_pkg::cell_t     cell_y,
    output logic                 active_d,
    output logic                 hsync_d,
    output logic                 vsync_d
);

    // the renderer takes the last stage
    localparam int DEPTH = board_pkg::RENDER_LATENCY - 1;
    localparam int PAY_W = 14;

    // returns {tile index, offset in tile}
    function automatic logic [9:0] split_axis(input logic [9:0] v, input int n);
        logic [9:0] r;
        r = {3'd0, v[6:0]};
        for (int k = 1; k < n; k++) begin
            if (v >= 10'(k * board_pkg::TILE_PX)) begin
                r = {3'(k), 7'(v - 10'(k * board_pkg::TILE_PX))};
            end
        end
        return r;
    endfunction

    function automatic board_pkg::cell_t cell_of(input board_pkg::tile_offset_t off);
        board_pkg::tile_offset_t q;
        q = (off - 7'(board_pkg::BORDER_PX)) / 7'(board_pkg::CELL_PX);
        return (q > 7'd7) ? 3'd7 : q[2:0];
    endfunction

    logic [9:0] bx;
    logic [9:0] sx;
    logic [9:0] sy;
    board_pkg::tile_offset_t off_x;
    board_pkg::tile_offset_t off_y;
    board_pkg::cell_t cx;
    board_pkg::cell_t cy;
    logic on_board_c;
    logic border_c;
    logic [PAY_W-1:0] pay_q [DEPTH];
    logic [2:0] ctrl_q [DEPTH];

    always_comb begin
        bx    = x - 10'(board_pkg::BOARD_X0);
        sx    = split_axis(bx, board_pkg::BOARD_COLS);
        sy    = split_axis({1'b0, y}, board_pkg::BOARD_ROWS);
        off_x = sx[6:0];
        off_y = sy[6:0];
        on_board_c = (x >= 10'(board_pkg::BOARD_X0)) &&
            (x < 10'(board_pkg::BOARD_X0 + board_pkg::BOARD_COLS * board_pkg::TILE_PX)) &&
            (y < 9'(board_pkg::BOARD_ROWS * board_pkg::TILE_PX));
        border_c = (off_x < 7'(board_pkg::BORDER_PX)) ||
            (off_x >= 7'(board_pkg::TILE_PX - board_pkg::BORDER_PX)) ||
            (off_y < 7'(board_pkg::BORDER_PX)) ||
            (off_y >= 7'(board_pkg::TILE_PX - board_pkg::BORDER_PX));
        cx = border_c ? 3'd0 : cell_of(off_x);
        cy = border_c ? 3'd0 : cell_of(off_y);
    end

    always_ff @(posedge clk) begin
        pay_q[0] <= {on_board_c, sy[9:7], sx[9:7], border_c, cx, cy};
        for (int i = 1; i < DEPTH; i++) begin
            pay_q[i] <= pay_q[i-1];
        end
    end

    // idle panel: not active, syncs high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctrl_q[i] <= 3'b011;
            end
        end else begin
            ctrl_q[0] <= {active, hsync, vsync};
            for (int i = 1; i < DEPTH; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    assign {on_board, row, col, in_border, cell_x, cell_y} = pay_q[DEPTH-1];
    assign {active_d, hsync_d, vsync_d} = ctrl_q[DEPTH-1];

endmodule

`default_nettype wire

/* rtl/board_renderer.sv */
`timescale 1ns/100ps
`default_nettype none

module board_renderer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              on_board,
    input  wire board_pkg::tile_row_t        row,
    input  wire board_pkg::tile_col_t        col,
    input  wire                              in_border,
    input  wire board_pkg::cell_t            cell_x,
    input  wire board_pkg::cell_t            cell_y,
    input  wire                              active_d,
    input  wire                              hsync_d,
    input  wire                              vsync_d,
    input  wire [4*board_pkg::NUM_EDGES-1:0] edge_colors,
    input  wire board_pkg::player_pos_t      p1_pos,
    input  wire board_pkg::player_pos_t      p2_pos,
    input  wire board_pkg::player_pos_t      p3_pos,
    input  wire board_pkg::player_pos_t      p4_pos,
    output board_pkg::rgb_t                  rgb,
    output logic                             den,
    output logic                             hsync,
    output logic                             vsync
);

    localparam board_pkg::tile_row_t LAST_ROW = 3'(board_pkg::BOARD_ROWS - 1);
    localparam board_pkg::tile_col_t LAST_COL = 3'(board_pkg::BOARD_COLS - 1);

    board_pkg::player_pos_t pos [board_pkg::NUM_PLAYERS];
    board_pkg::player_pos_t edge_idx;
    board_pkg::color_code_t edge_code;
    board_pkg::color_code_t code;
    board_pkg::glyph_t ctr_glyph;
    board_pkg::glyph_t tok_glyph;
    board_pkg::glyph_t sel_glyph;
    logic is_perim;
    logic has_glyph;
    logic hit;
    logic art_bit;

    // perimeter index, clockwise from the top-left corner
    always_comb begin
        is_perim = (row == 3'd0) || (row == LAST_ROW) || (col == 3'd0) || (col == LAST_COL);
        if (row == 3'd0) begin
            edge_idx = 5'(col);
        end else if (col == LAST_COL) begin
            edge_idx = 5'd7 + 5'(row);
        end else if (row == LAST_ROW) begin
            edge_idx = 5'd19 - 5'(col);
        end else begin
            edge_idx = 5'd24 - 5'(row);
        end
        edge_code = edge_colors[4 * (board_pkg::NUM_EDGES - 1 - int'(edge_idx)) +: 4];
    end

    always_comb begin
        ctr_glyph = board_pkg::GLYPH_0;
        has_glyph = 1'b1;
        case (row)
            3'd1: begin
                if (col == 3'd1) ctr_glyph = board_pkg::GLYPH_NW;
                else if (col == 3'd6) ctr_glyph = board_pkg::GLYPH_NE;
                else has_glyph = 1'b0;
            end
            3'd4: begin
                if (col == 3'd1) ctr_glyph = board_pkg::GLYPH_SW;
                else if (col == 3'd6) ctr_glyph = board_pkg::GLYPH_SE;
                else has_glyph = 1'b0;
            end
            // digits 1 to 6
            3'd2: ctr_glyph = 5'(col);
            3'd3: begin
                if (col <= 3'd3) ctr_glyph = 5'(col) + 5'd6;
                else if (col == 3'd4) ctr_glyph = board_pkg::GLYPH_0;
                else if (col == 3'd5) ctr_glyph = board_pkg::GLYPH_SHARP;
                else ctr_glyph = board_pkg::GLYPH_STAR;
            end
            default: has_glyph = 1'b0;
        endcase
    end

    // scan from p4 down so the lowest player wins
    always_comb begin
        pos = '{p1_pos, p2_pos, p3_pos, p4_pos};
        hit = 1'b0;
        tok_glyph = board_pkg::GLYPH_P1;
        for (int i = board_pkg::NUM_PLAYERS - 1; i >= 0; i--) begin
            if (pos[i] == edge_idx) begin
                hit = 1'b1;
                tok_glyph = board_pkg::GLYPH_P1 + 5'(i);
            end
        end
        sel_glyph = is_perim ? tok_glyph : ctr_glyph;
        art_bit = board_pkg::glyph_bit(sel_glyph, cell_y, cell_x);
    end

    always_comb begin
        code = board_pkg::BLACK;
        if (active_d && on_board) begin
            if (in_border) begin
                code = is_perim ? board_pkg::WHITE : board_pkg::BLACK;
            end else if (is_perim) begin
                code = (hit && art_bit) ? board_pkg::BROWN : edge_code;
            end else if (has_glyph && art_bit) begin
                code = board_pkg::WHITE;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb   <= '0;
            den   <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= board_pkg::palette(code);
            den   <= active_d;
            hsync <= hsync_d;
            vsync <= vsync_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/board_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module board_display_top #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 48,
    parameter int H_BACK   = 168,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 13,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 29
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [4*board_pkg::NUM_EDGES-1:0] edge_colors,
    input  wire board_pkg::player_pos_t      p1_pos,
    input  wire board_pkg::player_pos_t      p2_pos,
    input  wire board_pkg::player_pos_t      p3_pos,
    input  wire board_pkg::player_pos_t      p4_pos,
    output logic                             den,
    output logic                             hsync,
    output logic                             vsync,
    output logic [7:0]                       r,
    output logic [7:0]                       g,
    output logic [7:0]                       b
);

    logic [9:0] x;
    logic [8:0] y;
    logic active;
    logic hs_raw;
    logic vs_raw;
    logic on_board;
    board_pkg::tile_row_t row;
    board_pkg::tile_col_t col;
    logic in_border;
    board_pkg::cell_t cell_x;
    board_pkg::cell_t cell_y;
    logic active_d;
    logic hsync_d;
    logic vsync_d;
    board_pkg::rgb_t rgb;

    lcd_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing_i (
        .clk(clk), .rst(rst), .x(x), .y(y),
        .active(active), .hsync(hs_raw), .vsync(vs_raw)
    );

    tile_locator locator_i (
        .clk(clk), .rst(rst), .x(x), .y(y),
        .active(active), .hsync(hs_raw), .vsync(vs_raw),
        .on_board(on_board), .row(row), .col(col), .in_border(in_border),
        .cell_x(cell_x), .cell_y(cell_y),
        .active_d(active_d), .hsync_d(hsync_d), .vsync_d(vsync_d)
    );

    board_renderer renderer_i (
        .clk(clk), .rst(rst), .on_board(on_board), .row(row), .col(col),
        .in_border(in_border), .cell_x(cell_x), .cell_y(cell_y),
        .active_d(active_d), .hsync_d(hsync_d), .vsync_d(vsync_d),
        .edge_colors(edge_colors),
        .p1_pos(p1_pos), .p2_pos(p2_pos), .p3_pos(p3_pos), .p4_pos(p4_pos),
        .rgb(rgb), .den(den), .hsync(hsync), .vsync(vsync)
    );

    assign r = rgb[23:16];
    assign g = rgb[15:8];
    assign b = rgb[7:0];

endmodule

`default_nettype wire

/* sim/board_display_props.sv */
`timescale 1ns/100ps
`default_nettype none

module board_display_props #(
    parameter int H_SYNC = 48
) (
    input wire       clk,
    input wire       rst,
    input wire       den,
    input wire       hsync,
    input wire       vsync,
    input wire [7:0] r,
    input wire [7:0] g,
    input wire [7:0] b
);

    int low_cycles;

    // low hsync samples before the current edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_cycles <= 0;
        end else if (!hsync) begin
            low_cycles <= low_cycles + 1;
        end else begin
            low_cycles <= 0;
        end
    end

    den_outside_sync: assert property (@(posedge clk) disable iff (rst)
        den |-> (hsync && vsync))
        else $error("den high during a sync pulse");

    blank_is_black: assert property (@(posedge clk) disable iff (rst)
        !den |-> (r == 8'd0 && g == 8'd0 && b == 8'd0))
        else $error("rgb not zero while den is low");

    hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (low_cycles == H_SYNC))
        else $error("hsync pulse width differs from H_SYNC");

endmodule

`default_nettype wire

/* sim/board_display_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module board_display_tb;

    localparam int H_TOTAL = 1056;
    localparam int V_TOTAL = 525;
    localparam int NUM_TESTS = 5;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 3 * H_TOTAL * V_TOTAL * 8;

    logic clk;
    logic rst;
    logic [4*board_pkg::NUM_EDGES-1:0] edge_colors;
    board_pkg::player_pos_t p1_pos;
    board_pkg::player_pos_t p2_pos;
    board_pkg::player_pos_t p3_pos;
    board_pkg::player_pos_t p4_pos;
    logic den;
    logic hsync;
    logic vsync;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic [31:0] lfsr;

    board_display_top dut_i (
        .clk(clk), .rst(rst), .edge_colors(edge_colors),
        .p1_pos(p1_pos), .p2_pos(p2_pos), .p3_pos(p3_pos), .p4_pos(p4_pos),
        .den(den), .hsync(hsync), .vsync(vsync), .r(r), .g(g), .b(b)
    );

    bind board_display_top board_display_props #(.H_SYNC(H_SYNC)) props_i (
        .clk(clk), .rst(rst), .den(den), .hsync(hsync), .vsync(vsync),
        .r(r), .g(g), .b(b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the frames did not complete in the expected time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // reference colour of one active pixel
    function automatic board_pkg::rgb_t expected_rgb(input int x, input int y);
        int bx;
        int col;
        int row;
        int ox;
        int oy;
        int cx;
        int cy;
        int idx;
        int who;
        logic perim;
        logic blank;
        board_pkg::color_code_t code;
        board_pkg::glyph_t gl;
        board_pkg::player_pos_t pos [board_pkg::NUM_PLAYERS];
        bx = x - board_pkg::BOARD_X0;
        if (bx < 0 || bx >= board_pkg::BOARD_COLS * board_pkg::TILE_PX) begin
            return 24'h000000;
        end
        col = bx / board_pkg::TILE_PX;
        ox = bx % board_pkg::TILE_PX;
        row = y / board_pkg::TILE_PX;
        oy = y % board_pkg::TILE_PX;
        perim = (row == 0) || (row == board_pkg::BOARD_ROWS - 1) ||
            (col == 0) || (col == board_pkg::BOARD_COLS - 1);
        if (ox < 2 || ox >= 78 || oy < 2 || oy >= 78) begin
            return perim ? 24'hffffff : 24'h000000;
        end
        cx = (ox - board_pkg::BORDER_PX) / board_pkg::CELL_PX;
        cy = (oy - board_pkg::BORDER_PX) / board_pkg::CELL_PX;
        cx = (cx > 7) ? 7 : cx;
        cy = (cy > 7) ? 7 : cy;
        if (perim) begin
            if (row == 0) begin
                idx = col;
            end else if (col == 7) begin
                idx = 7 + row;
            end else if (row == 5) begin
                idx = 13 + (6 - col);
            end else begin
                idx = 20 + (4 - row);
            end
            pos = '{p1_pos, p2_pos, p3_pos, p4_pos};
            who = -1;
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                if (who < 0 && int'(pos[i]) == idx) begin
                    who = i;
                end
            end
            gl = board_pkg::GLYPH_P1 + 5'(who);
            if (who >= 0 && board_pkg::glyph_bit(gl, 3'(cy), 3'(cx))) begin
                return 24'ha52a2a;
            end
            code = edge_colors[4 * (board_pkg::NUM_EDGES - 1 - idx) +: 4];
            // codes past brown show as black
            return (code > board_pkg::BROWN) ? 24'h000000 : board_pkg::palette(code);
        end
        blank = 1'b0;
        gl = board_pkg::GLYPH_0;
        if (row == 1 || row == 4) begin
            if (col == 1) begin
                gl = (row == 1) ? board_pkg::GLYPH_NW : board_pkg::GLYPH_SW;
            end else if (col == 6) begin
                gl = (row == 1) ? board_pkg::GLYPH_NE : board_pkg::GLYPH_SE;
            end else begin
                blank = 1'b1;
            end
        end else if (row == 2) begin
            gl = 5'(col);
        end else if (col <= 3) begin
            gl = 5'(col + 6);
        end else if (col == 5) begin
            gl = board_pkg::GLYPH_SHARP;
        end else if (col == 6) begin
            gl = board_pkg::GLYPH_STAR;
        end
        if (!blank && board_pkg::glyph_bit(gl, 3'(cy), 3'(cx))) begin
            return 24'hffffff;
        end
        return 24'h000000;
    endfunction

    // one frame between vsync pulses, one den run per line
    task automatic walk_frame(input bit check_pixels);
        int line_no;
        int px;
        bit prev_den;
        board_pkg::rgb_t exp;
        @(negedge clk);
        while (vsync !== 1'b0) @(negedge clk);
        while (vsync !== 1'b1) @(negedge clk);
        line_no = 0;
        px = 0;
        prev_den = 1'b0;
        while (vsync === 1'b1) begin
            if (den === 1'b1) begin
                exp = expected_rgb(px, line_no);
                if (check_pixels && {r, g, b} !== exp) begin
                    check_value($sformatf("rgb at x %0d y %0d", px, line_no),
                                32'({r, g, b}), 32'(exp));
                end
                px++;
            end else if (prev_den) begin
                check_value("den run length", px, 32'd800);
                line_no++;
                px = 0;
            end
            prev_den = den;
            @(negedge clk);
        end
        check_value("den runs per frame", line_no, 32'd480);
    endtask

    task automatic set_players(input int a, input int b2, input int c, input int d);
        p1_pos = 5'(a);
        p2_pos = 5'(b2);
        p3_pos = 5'(c);
        p4_pos = 5'(d);
    endtask

    task automatic test_reset_framing();
        repeat (10) @(negedge clk);
        check_value("den", 32'(den), 32'd0);
        check_value("hsync", 32'(hsync), 32'd1);
        check_value("vsync", 32'(vsync), 32'd1);
        check_value("rgb", 32'({r, g, b}), 32'd0);
        rst = 1'b0;
        @(negedge clk);
        check_value("den", 32'(den), 32'd0);
        check_value("hsync", 32'(hsync), 32'd1);
        check_value("vsync", 32'(vsync), 32'd1);
        check_value("rgb", 32'({r, g, b}), 32'd0);
        walk_frame(1'b0);
    endtask

    task automatic test_board_layout();
        // codes 0 to 12 cycle around the ring
        for (int i = 0; i < board_pkg::NUM_EDGES; i++) begin
            edge_colors[4 * (board_pkg::NUM_EDGES - 1 - i) +: 4] = 4'(i % 13);
        end
        set_players(31, 31, 31, 31);
        walk_frame(1'b1);
    endtask

    task automatic test_tokens();
        set_players(0, 8, 13, 23);
        walk_frame(1'b1);
    endtask

    task automatic test_priority();
        set_players(5, 24, 5, 31);
        walk_frame(1'b1);
    endtask

    task automatic test_random_colors();
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < board_pkg::NUM_EDGES; i++) begin
                edge_colors[4 * i +: 4] = 4'(rand_bits(4));
            end
            edge_colors[4 * 21 +: 4] = 4'd13;
            edge_colors[4 * 12 +: 4] = 4'd14;
            edge_colors[4 * 6 +: 4] = 4'd15;
            set_players(int'(rand_bits(5)), int'(rand_bits(5)),
                        int'(rand_bits(5)), int'(rand_bits(5)));
            walk_frame(1'b1);
        end
    endtask

    initial begin
        rst = 1'b1;
        edge_colors = '0;
        p1_pos = 5'd31;
        p2_pos = 5'd31;
        p3_pos = 5'd31;
        p4_pos = 5'd31;
        lfsr = 32'h26f0044b;
        test_reset_framing();
        test_board_layout();
        test_tokens();
        test_priority();
        test_random_colors();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/board_pkg.sv
rtl/lcd_timing.sv
rtl/tile_locator.sv
rtl/board_renderer.sv
rtl/board_display_top.sv
sim/board_display_props.sv
sim/board_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the board display testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module board_display_tb \
    -Mdir "$build_dir" \
    -o board_display_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/board_display_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "CHECKS FAILED" "$log_file"; then
    echo "simulation failed"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0
